/* vio_switch.f */
hw/vio_switch_pkg.sv
hw/axis_slice.sv
hw/ingress_decode.sv
hw/egress_arbiter.sv
hw/vio_switch.sv
verification/vio_switch_chk.sv
verification/tb_vio_switch.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vio_switch -Mdir obj_dir -f vio_switch.f

# Simulator status is ignored here, the search below decides pass or fail
sim_out=$(./obj_dir/Vtb_vio_switch 2>&1) || true
echo "$sim_out"

grep -qx "NO ERRORS" <<< "$sim_out"

/* verification/tb_vio_switch.sv */
// Testbench driving random packets through the vIO switch against a queue model
`timescale 1ns/1ps

module tb_vio_switch;

  typedef enum int {ROUTE, CONTEND, BAD_DEST} mode_e;

  logic aclk;
  logic rst;
  logic [vio_switch_pkg::N_PORTS-1:0]                  s_tvalid;
  logic [vio_switch_pkg::N_PORTS-1:0]                  s_tready;
  vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] s_tdata;
  vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  s_tid;
  logic [vio_switch_pkg::N_PORTS-1:0]                  s_tlast;
  vio_switch_pkg::dest_t [vio_switch_pkg::N_ID-1:0]    route_in;
  vio_switch_pkg::dest_t [vio_switch_pkg::N_NET-1:0]   s_tdest;
  logic [vio_switch_pkg::N_PORTS-1:0]                  m_tvalid;
  logic [vio_switch_pkg::N_PORTS-1:0]                  m_tready;
  vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] m_tdata;
  vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  m_tid;
  logic [vio_switch_pkg::N_PORTS-1:0]                  m_tlast;
  vio_switch_pkg::dest_t [vio_switch_pkg::N_ID-1:0]    route_out;
  vio_switch_pkg::dest_t [vio_switch_pkg::N_NET-1:0]   m_tdest;
  logic [vio_switch_pkg::N_PORTS-1:0]                  decode_err;

  // Expected beats kept in order per [source][output]
  vio_switch_pkg::beat_t exp_q[vio_switch_pkg::N_PORTS][vio_switch_pkg::N_PORTS][$];
  int                    pkt_left[vio_switch_pkg::N_PORTS];
  vio_switch_pkg::dest_t pkt_dest[vio_switch_pkg::N_PORTS];
  logic [27:0]           seq[vio_switch_pkg::N_PORTS];
  int                    pkt_src[vio_switch_pkg::N_PORTS];
  int                    bad_sent[vio_switch_pkg::N_PORTS];
  int                    err_seen[vio_switch_pkg::N_PORTS];
  int                    served[vio_switch_pkg::N_PORTS];
  logic [vio_switch_pkg::N_PORTS-1:0] src_en;
  integer seed;
  mode_e  mode;
  bit     gen_on;
  int     errors;
  int     tests;
  int     failed;

  vio_switch u_dut (
    .aclk       (aclk),
    .rst        (rst),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tid      (s_tid),
    .s_tlast    (s_tlast),
    .route_in   (route_in),
    .s_tdest    (s_tdest),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tid      (m_tid),
    .m_tlast    (m_tlast),
    .route_out  (route_out),
    .m_tdest    (m_tdest),
    .decode_err (decode_err)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic expect_eq(input string sig, input int idx, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s[%0d] got %h expected %h", $time, sig, idx, got, exp);
      errors++;
    end
  endtask

  function automatic vio_switch_pkg::dest_t pick_dest();
    vio_switch_pkg::port_sel_t port;
    logic [9:0] offset;
    port = 4'($unsigned($random(seed)) % 6);
    offset = 10'($random(seed));
    if (mode == CONTEND) begin
      port = '0;
    end else if (mode == BAD_DEST && ($random(seed) & 3) == 0) begin
      // Indices 6 to 15 lie outside the port map
      port = 4'(6 + $unsigned($random(seed)) % 10);
    end
    return {port, offset};
  endfunction

  // Destination and pid follow the per-class rules of the switch
  task automatic accept_input(input int p);
    vio_switch_pkg::beat_t b;
    b.data = s_tdata[p];
    b.last = s_tlast[p];
    if (p < vio_switch_pkg::PORT_HOST_BASE) begin
      b.dest = route_in[p];
      b.pid = s_tid[p];
    end else if (p < vio_switch_pkg::PORT_NET_BASE) begin
      b.dest = 14'((p - vio_switch_pkg::PORT_HOST_BASE) * 'h400);
      b.pid = '0;
    end else begin
      b.dest = s_tdest[p - vio_switch_pkg::PORT_NET_BASE];
      b.pid = s_tid[p];
    end
    if (b.dest[13:10] >= 4'd6) bad_sent[p]++;
    else exp_q[p][b.dest[13:10]].push_back(b);
  endtask

  task automatic check_output(input int o);
    int src;
    vio_switch_pkg::beat_t exp;
    src = int'(m_tdata[o][31:28]);
    if (src >= vio_switch_pkg::N_PORTS || exp_q[src][o].size() == 0) begin
      $display("ERROR t=%0t output %0d delivered beat %h that was never sent to it",
               $time, o, m_tdata[o]);
      errors++;
    end else begin
      exp = exp_q[src][o].pop_front();
      served[src]++;
      expect_eq("m_tdata", o, m_tdata[o], exp.data);
      expect_eq("m_tid", o, 32'(m_tid[o]), 32'(exp.pid));
      expect_eq("m_tlast", o, 32'(m_tlast[o]), 32'(exp.last));
      if (o < vio_switch_pkg::N_ID) expect_eq("route_out", o, 32'(route_out[o]), 32'(exp.dest));
      if (o >= vio_switch_pkg::PORT_NET_BASE) begin
        expect_eq("m_tdest", o - vio_switch_pkg::PORT_NET_BASE,
                  32'(m_tdest[o - vio_switch_pkg::PORT_NET_BASE]), 32'(exp.dest));
      end
      // A different source inside an open packet means interleaving
      if (pkt_src[o] >= 0 && pkt_src[o] != src) begin
        $display("ERROR t=%0t output %0d mixed source %0d into a packet from source %0d",
                 $time, o, src, pkt_src[o]);
        errors++;
      end
      pkt_src[o] = m_tlast[o] ? -1 : src;
    end
  endtask

  task automatic drive_source(input int p);
    if (pkt_left[p] == 0 && gen_on && src_en[p] && ($random(seed) & 1) == 0) begin
      pkt_left[p] = 1 + ($random(seed) & 3);
      pkt_dest[p] = pick_dest();
    end
    if (pkt_left[p] > 0) begin
      s_tvalid[p] = 1'b1;
      s_tdata[p] = {4'(p), seq[p]};
      seq[p] = seq[p] + 1'b1;
      s_tid[p] = 6'($random(seed));
      s_tlast[p] = (pkt_left[p] == 1);
      pkt_left[p]--;
      if (p < vio_switch_pkg::PORT_HOST_BASE) route_in[p] = pkt_dest[p];
      if (p >= vio_switch_pkg::PORT_NET_BASE) begin
        s_tdest[p - vio_switch_pkg::PORT_NET_BASE] = pkt_dest[p];
      end
    end
  endtask

  // Sample handshakes mid-cycle, then drive 1 ns after the next rising edge
  task automatic step();
    logic [vio_switch_pkg::N_PORTS-1:0] acc;
    @(negedge aclk);
    acc = s_tvalid & s_tready;
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      if (acc[p]) accept_input(p);
      if (decode_err[p]) err_seen[p]++;
      if (m_tvalid[p] && m_tready[p]) check_output(p);
    end
    @(posedge aclk);
    #1;
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      if (acc[p]) s_tvalid[p] = 1'b0;
      if (!s_tvalid[p]) drive_source(p);
      m_tready[p] = ($random(seed) & 3) != 0;
    end
  endtask

  function automatic bit drained();
    bit done;
    done = (s_tvalid == '0);
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      if (pkt_left[p] != 0) done = 1'b0;
      for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
        if (exp_q[p][o].size() != 0) done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic run_test(input string name, input mode_e m,
                          input logic [vio_switch_pkg::N_PORTS-1:0] en, input int cycles);
    int errors_before;
    int waited;
    errors_before = errors;
    mode = m;
    src_en = en;
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      bad_sent[p] = 0;
      err_seen[p] = 0;
      served[p] = 0;
    end
    gen_on = 1'b1;
    repeat (cycles) step();
    gen_on = 1'b0;
    waited = 0;
    while (!drained() && waited < 2000) begin
      step();
      waited++;
    end
    if (!drained()) begin
      $display("ERROR test %s: traffic did not drain within 2000 cycles", name);
      errors++;
    end
    // Bad beats still in the ingress registers retire here
    repeat (4) step();
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      expect_eq("decode_err_count", p, 32'(err_seen[p]), 32'(bad_sent[p]));
      if (src_en[p] && served[p] == 0) begin
        $display("ERROR test %s: source %0d was never served", name, p);
        errors++;
      end
    end
    tests++;
    if (errors == errors_before) begin
      $display("test %s passed", name);
    end else begin
      failed++;
      $display("test %s failed", name);
    end
  endtask

  initial begin
    seed = 32'ha9bc;
    errors = 0;
    tests = 0;
    failed = 0;
    gen_on = 1'b0;
    mode = ROUTE;
    src_en = '0;
    rst = 1'b1;
    s_tvalid = '0;
    s_tdata = '0;
    s_tid = '0;
    s_tlast = '0;
    route_in = '0;
    s_tdest = '0;
    m_tready = '0;
    for (int p = 0; p < vio_switch_pkg::N_PORTS; p++) begin
      pkt_left[p] = 0;
      seq[p] = '0;
      pkt_src[p] = -1;
    end
    repeat (5) @(posedge aclk);
    #1;
    rst = 1'b0;
    @(negedge aclk);
    tests++;
    if (m_tvalid != '0) begin
      $display("CHECK FAILED t=%0t m_tvalid got %b expected 0", $time, m_tvalid);
      errors++;
      failed++;
      $display("test reset_release failed");
    end else begin
      $display("test reset_release passed");
    end
    run_test("vfiu_net_routing", ROUTE, 6'b110011, 400);
    run_test("host_path", ROUTE, 6'b001100, 300);
    run_test("contention", CONTEND, 6'b110111, 600);
    run_test("bad_dest", BAD_DEST, 6'b111111, 500);
    run_test("mixed_backpressure", ROUTE, 6'b111111, 800);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verification/vio_switch_chk.sv */
// Concurrent assertions on the vIO switch handshakes, reset state and decode errors
`timescale 1ns/1ps

module vio_switch_chk (
  input logic                                              aclk,
  input logic                                              rst,
  input logic [vio_switch_pkg::N_PORTS-1:0]                s_tvalid,
  input logic [vio_switch_pkg::N_PORTS-1:0]                s_tready,
  input vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] s_tdata,
  input vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  s_tid,
  input logic [vio_switch_pkg::N_PORTS-1:0]                s_tlast,
  input logic [vio_switch_pkg::N_PORTS-1:0]                m_tvalid,
  input logic [vio_switch_pkg::N_PORTS-1:0]                m_tready,
  input vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] m_tdata,
  input vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  m_tid,
  input logic [vio_switch_pkg::N_PORTS-1:0]                m_tlast,
  input logic [vio_switch_pkg::N_PORTS-1:0]                decode_err
);

  for (genvar p = 0; p < vio_switch_pkg::N_PORTS; p++) begin : g_port
    // A stalled input beat holds still until taken
    a_in_hold: assert property (@(posedge aclk) disable iff (rst)
      s_tvalid[p] && !s_tready[p] |=> s_tvalid[p] && $stable(s_tdata[p])
        && $stable(s_tid[p]) && $stable(s_tlast[p]))
      else $error("input %0d beat changed while stalled", p);

    a_out_hold: assert property (@(posedge aclk) disable iff (rst)
      m_tvalid[p] && !m_tready[p] |=> m_tvalid[p] && $stable(m_tdata[p])
        && $stable(m_tid[p]) && $stable(m_tlast[p]))
      else $error("output %0d beat changed while stalled", p);

    // A bad beat is dropped one cycle after its input took it, freeing the input
    a_err_drop: assert property (@(posedge aclk) disable iff (rst)
      decode_err[p] |-> s_tready[p] && $past(s_tvalid[p] && s_tready[p]))
      else $error("input %0d decode_err without a just accepted beat", p);
  end

  a_reset_quiet: assert property (@(posedge aclk)
    $past(rst) |-> m_tvalid == '0 && decode_err == '0)
    else $error("outputs active right after reset");

endmodule

bind vio_switch vio_switch_chk u_chk (.*);

/* hw/vio_switch.sv */
// vIO packet switch top joining ingress decode, packet arbitration and egress registers
`timescale 1ns/1ps

module vio_switch (
  input  logic aclk,
  input  logic rst,

  input  logic [vio_switch_pkg::N_PORTS-1:0]                  s_tvalid,
  output logic [vio_switch_pkg::N_PORTS-1:0]                  s_tready,
  input  vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] s_tdata,
  input  vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  s_tid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                  s_tlast,
  input  vio_switch_pkg::dest_t [vio_switch_pkg::N_ID-1:0]    route_in,
  input  vio_switch_pkg::dest_t [vio_switch_pkg::N_NET-1:0]   s_tdest,

  output logic [vio_switch_pkg::N_PORTS-1:0]                  m_tvalid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                  m_tready,
  output vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0] m_tdata,
  output vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]  m_tid,
  output logic [vio_switch_pkg::N_PORTS-1:0]                  m_tlast,
  output vio_switch_pkg::dest_t [vio_switch_pkg::N_ID-1:0]    route_out,
  output vio_switch_pkg::dest_t [vio_switch_pkg::N_NET-1:0]   m_tdest,

  output logic [vio_switch_pkg::N_PORTS-1:0]                  decode_err
);

  logic [vio_switch_pkg::N_PORTS-1:0]                      in_valid;
  logic [vio_switch_pkg::N_PORTS-1:0]                      in_ready;
  vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     in_beat;
  vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] in_port;
  logic [vio_switch_pkg::N_PORTS-1:0]                      in_bad;

  logic [vio_switch_pkg::N_PORTS-1:0]                      arb_valid;
  logic [vio_switch_pkg::N_PORTS-1:0]                      arb_ready;
  vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     arb_beat;

  vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     eg_beat;

  ingress_decode u_ingress (
    .aclk     (aclk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tid    (s_tid),
    .s_tlast  (s_tlast),
    .route_in (route_in),
    .s_tdest  (s_tdest),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_beat  (in_beat),
    .in_port  (in_port),
    .in_bad   (in_bad)
  );

  egress_arbiter u_arbiter (
    .aclk       (aclk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .in_port    (in_port),
    .in_bad     (in_bad),
    .arb_valid  (arb_valid),
    .arb_ready  (arb_ready),
    .arb_beat   (arb_beat),
    .decode_err (decode_err)
  );

  // Egress register per output port
  for (genvar p = 0; p < vio_switch_pkg::N_PORTS; p++) begin : g_egress
    axis_slice #(.T(vio_switch_pkg::beat_t)) u_slice (
      .aclk      (aclk),
      .rst       (rst),
      .in_valid  (arb_valid[p]),
      .in_ready  (arb_ready[p]),
      .in_data   (arb_beat[p]),
      .out_valid (m_tvalid[p]),
      .out_ready (m_tready[p]),
      .out_data  (eg_beat[p])
    );

    assign m_tdata[p] = eg_beat[p].data;
    assign m_tid[p] = eg_beat[p].pid;
    assign m_tlast[p] = eg_beat[p].last;
  end

  // vFIU outputs report their route, network outputs their tdest
  for (genvar i = 0; i < vio_switch_pkg::N_ID; i++) begin : g_route_out
    assign route_out[i] = eg_beat[vio_switch_pkg::PORT_VFIU_BASE + i].dest;
  end

  for (genvar i = 0; i < vio_switch_pkg::N_NET; i++) begin : g_net_dest
    assign m_tdest[i] = eg_beat[vio_switch_pkg::PORT_NET_BASE + i].dest;
  end

endmodule

/* hw/egress_arbiter.sv */
// Per-output round-robin packet arbiter that also discards beats with bad ports
`timescale 1ns/1ps

module egress_arbiter (
  input  logic aclk,
  input  logic rst,

  input  logic [vio_switch_pkg::N_PORTS-1:0]                      in_valid,
  output logic [vio_switch_pkg::N_PORTS-1:0]                      in_ready,
  input  vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     in_beat,
  input  vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] in_port,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                      in_bad,

  output logic [vio_switch_pkg::N_PORTS-1:0]                      arb_valid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                      arb_ready,
  output vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     arb_beat,

  output logic [vio_switch_pkg::N_PORTS-1:0]                      decode_err
);

  // Indexed [output][input]
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::N_PORTS-1:0] req;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::N_PORTS-1:0] gnt;

  vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] win;
  vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] lock_src;
  vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] rr_ptr;
  logic [vio_switch_pkg::N_PORTS-1:0]                      locked;

  // Bad beats leave straight from the ingress register
  assign decode_err = in_valid & in_bad;

  always_comb begin
    for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
      for (int i = 0; i < vio_switch_pkg::N_PORTS; i++) begin
        req[o][i] = in_valid[i] && !in_bad[i]
                    && (in_port[i] == vio_switch_pkg::port_sel_t'(o));
      end
    end
  end

  // Locked output keeps its source, otherwise the lowest requester at or
  // after the pointer wins, wrapping to the lowest overall
  always_comb begin
    int sel;
    for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
      sel = -1;
      if (locked[o]) begin
        sel = int'(lock_src[o]);
      end else begin
        for (int i = vio_switch_pkg::N_PORTS - 1; i >= 0; i--) begin
          if (req[o][i]) sel = i;
        end
        for (int i = vio_switch_pkg::N_PORTS - 1; i >= 0; i--) begin
          if (req[o][i] && i >= int'(rr_ptr[o])) sel = i;
        end
      end
      win[o] = vio_switch_pkg::port_sel_t'(sel);
      for (int i = 0; i < vio_switch_pkg::N_PORTS; i++) begin
        gnt[o][i] = req[o][i] && (i == sel);
      end
    end
  end

  always_comb begin
    for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
      arb_valid[o] = |gnt[o];
      arb_beat[o] = '0;
      for (int i = 0; i < vio_switch_pkg::N_PORTS; i++) begin
        if (gnt[o][i]) arb_beat[o] = in_beat[i];
      end
    end
  end

  // An input drains when discarded or when its granted output takes the beat
  always_comb begin
    for (int i = 0; i < vio_switch_pkg::N_PORTS; i++) begin
      in_ready[i] = in_bad[i];
      for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
        if (gnt[o][i] && arb_ready[o]) in_ready[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      locked <= '0;
      lock_src <= '0;
      rr_ptr <= '0;
    end else begin
      for (int o = 0; o < vio_switch_pkg::N_PORTS; o++) begin
        if (arb_valid[o] && arb_ready[o]) begin
          // Hold the grant until the packet's last beat is taken
          locked[o] <= !arb_beat[o].last;
          lock_src[o] <= win[o];
          if (win[o] == vio_switch_pkg::port_sel_t'(vio_switch_pkg::N_PORTS - 1)) begin
            rr_ptr[o] <= '0;
          end else begin
            rr_ptr[o] <= win[o] + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* hw/ingress_decode.sv */
// Ingress stage choosing each input's destination, decoding its port and registering it
`timescale 1ns/1ps

module ingress_decode (
  input  logic aclk,
  input  logic rst,

  input  logic [vio_switch_pkg::N_PORTS-1:0]                      s_tvalid,
  output logic [vio_switch_pkg::N_PORTS-1:0]                      s_tready,
  input  vio_switch_pkg::data_t [vio_switch_pkg::N_PORTS-1:0]     s_tdata,
  input  vio_switch_pkg::pid_t [vio_switch_pkg::N_PORTS-1:0]      s_tid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                      s_tlast,
  input  vio_switch_pkg::dest_t [vio_switch_pkg::N_ID-1:0]        route_in,
  input  vio_switch_pkg::dest_t [vio_switch_pkg::N_NET-1:0]       s_tdest,

  output logic [vio_switch_pkg::N_PORTS-1:0]                      in_valid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                      in_ready,
  output vio_switch_pkg::beat_t [vio_switch_pkg::N_PORTS-1:0]     in_beat,
  output vio_switch_pkg::port_sel_t [vio_switch_pkg::N_PORTS-1:0] in_port,
  output logic [vio_switch_pkg::N_PORTS-1:0]                      in_bad
);

  for (genvar p = 0; p < vio_switch_pkg::N_PORTS; p++) begin : g_port
    vio_switch_pkg::dest_t   dest;
    vio_switch_pkg::pid_t    pid;
    vio_switch_pkg::routed_t dec;
    vio_switch_pkg::routed_t held;

    if (p < vio_switch_pkg::PORT_HOST_BASE) begin : g_vfiu
      // User region supplies its route from the shell
      assign dest = route_in[p - vio_switch_pkg::PORT_VFIU_BASE];
      assign pid = s_tid[p];
    end else if (p < vio_switch_pkg::PORT_NET_BASE) begin : g_host
      // Host i always lands on vFIU i with pid zero
      assign dest = vio_switch_pkg::dest_t'((p - vio_switch_pkg::PORT_HOST_BASE)
                                            << vio_switch_pkg::DEST_PORT_LSB);
      assign pid = '0;
    end else begin : g_net
      assign dest = s_tdest[p - vio_switch_pkg::PORT_NET_BASE];
      assign pid = s_tid[p];
    end

    assign dec.beat = '{data: s_tdata[p], pid: pid, dest: dest, last: s_tlast[p]};
    assign dec.port = dest[vio_switch_pkg::DEST_BITS-1:vio_switch_pkg::DEST_PORT_LSB];
    assign dec.bad = dec.port >= vio_switch_pkg::port_sel_t'(vio_switch_pkg::N_PORTS);

    axis_slice #(.T(vio_switch_pkg::routed_t)) u_slice (
      .aclk      (aclk),
      .rst       (rst),
      .in_valid  (s_tvalid[p]),
      .in_ready  (s_tready[p]),
      .in_data   (dec),
      .out_valid (in_valid[p]),
      .out_ready (in_ready[p]),
      .out_data  (held)
    );

    assign in_beat[p] = held.beat;
    assign in_port[p] = held.port;
    assign in_bad[p] = held.bad;
  end

endmodule

/* hw/axis_slice.sv */
// Single-entry ready/valid register stage carrying a payload of any type
`timescale 1ns/1ps

module axis_slice #(
  parameter type T = logic
) (
  input  logic aclk,
  input  logic rst,

  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,

  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic full;
  T     data_q;

  // Accept when empty or when the held item leaves in this same cycle
  assign in_ready = !full || out_ready;

  assign out_valid = full;
  assign out_data = data_q;

  always_ff @(posedge aclk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_ready) begin
      // Refill or drain depending on whether a new item arrives
      full <= in_valid;
    end
  end

  // Payload register, loaded on every accepted item
  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

/* hw/vio_switch_pkg.sv */
// Port map, field widths and beat types shared by the vIO packet switch
package vio_switch_pkg;

  // Port counts per class
  localparam int N_ID = 2;
  localparam int N_NET = 2;
  localparam int N_PORTS = 2 * N_ID + N_NET;

  // Ports are ordered vFIU, then host, then network
  localparam int PORT_VFIU_BASE = 0;
  localparam int PORT_HOST_BASE = N_ID;
  localparam int PORT_NET_BASE = 2 * N_ID;

  // Field widths
  localparam int DATA_BITS = 32;
  localparam int PID_BITS = 6;
  localparam int DEST_BITS = 14;

  // Output port index sits in the upper destination bits, one port per 0x400
  localparam int DEST_PORT_LSB = 10;
  localparam int PORT_SEL_BITS = DEST_BITS - DEST_PORT_LSB;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [PID_BITS-1:0] pid_t;
  typedef logic [DEST_BITS-1:0] dest_t;
  typedef logic [PORT_SEL_BITS-1:0] port_sel_t;

  // One stream beat as it travels through arbitration and egress
  typedef struct packed {
    data_t data;
    pid_t  pid;
    dest_t dest;
    logic  last;
  } beat_t;

  // Beat with its decoded output port, held in the ingress register
  typedef struct packed {
    beat_t     beat;
    port_sel_t port;
    logic      bad;
  } routed_t;

endpackage
